/* src/obj_config.svh */
// object scanner sizes: table depth, address width, entries, tile size, drawer time

`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

// table depth in 16-bit words
`define OBJ_TABLE_WORDS 1024

// table address width
`define OBJ_ADDR_W 10

// entries per table, four words each
`define OBJ_ENTRIES 256

// tile width and height in pixels
`define OBJ_TILE_PX 16

// drawer busy cycles per request, two or more
`define OBJ_DRAW_CYCLES 6

`endif

/* src/obj_pkg.sv */
// object scanner package: scan state enum, table word and field types

package obj_pkg;

    // scanner FSM states, one table word addressed per read state
    typedef enum logic [3:0] {
        SCAN_IDLE = 4'd0, // waiting for start
        SCAN_ATTR = 4'd1, // attr word addressed
        SCAN_CODE = 4'd2, // code word addressed, attr arrives
        SCAN_Y    = 4'd3, // y word addressed, code arrives
        SCAN_X    = 4'd4, // x word addressed, y arrives
        SCAN_MAP  = 4'd5, // x arrives, bank result ready
        SCAN_VIS  = 4'd6, // zone and repeat test
        SCAN_REQ  = 4'd7, // waiting for drawer idle
        SCAN_HOLD = 4'd8, // request strobe out, step column
        SCAN_NEXT = 4'd9  // entry finished
    } scan_state_t;

    // one 16-bit word of the object table
    typedef logic [15:0] obj_word_t;

    // screen coordinates, both 9 bits wide
    typedef logic [8:0] obj_hpos_t;
    typedef logic [8:0] obj_line_t;

    // nibble fields: bank bits, tile column, sub-row
    typedef logic [3:0] obj_nib_t;

endpackage

/* src/obj_frame_table.sv */
// frame table RAM: host write port and registered scan read port

`timescale 1ns/1ns
`include "obj_config.svh"

module obj_frame_table (
    input  logic                   clk,
    input  logic                   table_we,
    input  logic [`OBJ_ADDR_W-1:0] table_addr,
    input  obj_pkg::obj_word_t     table_din,
    input  logic [`OBJ_ADDR_W-1:0] rd_addr,
    output obj_pkg::obj_word_t     rd_data
);
    import obj_pkg::*;

    obj_word_t mem [0:`OBJ_TABLE_WORDS-1]; // four words per entry

    // host side, loaded between scans
    always_ff @(posedge clk) begin
        if (table_we) begin
            mem[table_addr] <= table_din;
        end
    end

    // scan side, data one cycle after address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* src/obj_bank_mapper.sv */
// bank mapper: mask and offset of the upper code nibble, unmapped flag

`timescale 1ns/1ns

module obj_bank_mapper (
    input  logic              clk,
    input  logic              rst,
    input  obj_pkg::obj_nib_t code_hi,
    input  obj_pkg::obj_nib_t bank_mask,
    input  obj_pkg::obj_nib_t bank_offset,
    output obj_pkg::obj_nib_t map_hi,
    output logic              unmapped
);

    // one cycle from code_hi to result
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            map_hi   <= 4'd0;
            unmapped <= 1'b0;
        end else begin
            map_hi   <= (code_hi & bank_mask) | bank_offset; // keep masked bits, add bank
            unmapped <= |(code_hi & ~bank_mask);             // any bit outside the bank
        end
    end

    // mapped nibble only ever carries mask or offset bits of the cycle before
    a_map_bits : assert property (
        @(posedge clk) disable iff (rst)
        (map_hi & ~($past(bank_mask) | $past(bank_offset))) == 4'd0
    ) else $error("bank mapper: map_hi %h outside mask/offset", map_hi);

endmodule

/* src/obj_tile_match.sv */
// tile match: vertical zone test, row and sub-row with vflip, tile code of a column

`timescale 1ns/1ns
`include "obj_config.svh"

module obj_tile_match (
    input  obj_pkg::obj_word_t obj_code,
    input  obj_pkg::obj_word_t obj_attr,
    input  obj_pkg::obj_word_t obj_y,
    input  obj_pkg::obj_line_t line,
    input  obj_pkg::obj_nib_t  col,
    output logic               inzone,
    output obj_pkg::obj_nib_t  vsub,
    output obj_pkg::obj_word_t code_mn
);
    import obj_pkg::*;

    obj_line_t dy;       // line offset into the object, mod 512
    obj_nib_t  tile_m;   // extra tile rows
    logic      vflip;
    logic [9:0] zone_h;  // object height in lines, up to 256
    obj_nib_t  row_raw;
    obj_nib_t  sub_raw;
    obj_nib_t  row;      // row after vflip

    assign tile_m = obj_attr[15:12];
    assign vflip  = obj_attr[6];

    assign dy     = line - obj_y[8:0]; // wraps on 9 bits
    assign zone_h = ({6'd0, tile_m} + 10'd1) * 10'(`OBJ_TILE_PX);
    assign inzone = {1'b0, dy} < zone_h;

    // only meaningful while inzone, dy below 256 then
    assign row_raw = obj_nib_t'(dy / `OBJ_TILE_PX);
    assign sub_raw = obj_nib_t'(dy % `OBJ_TILE_PX);

    // vertical flip mirrors rows within the object and lines within the tile
    assign row  = vflip ? tile_m - row_raw : row_raw;
    assign vsub = vflip ? ~sub_raw : sub_raw; // 15 - sub

    // tiles laid out 16 codes per row in the ROM
    assign code_mn = obj_code + {12'd0, col} + {8'd0, row, 4'd0};

endmodule

/* src/obj_line_scan.sv */
// object line scanner: FSM walking the table, bank/zone/repeat filter, column expansion

`timescale 1ns/1ns
`include "obj_config.svh"

module obj_line_scan (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   flip,
    input  obj_pkg::obj_line_t     vrender,
    input  obj_pkg::obj_nib_t      bank_mask,
    input  obj_pkg::obj_nib_t      bank_offset,
    input  obj_pkg::obj_word_t     rd_data,
    input  obj_pkg::obj_nib_t      map_hi,
    input  logic                   unmapped,
    input  logic                   inzone,
    input  obj_pkg::obj_nib_t      vsub,
    input  obj_pkg::obj_word_t     code_mn,
    input  logic                   dr_idle,
    output logic [`OBJ_ADDR_W-1:0] rd_addr,
    output obj_pkg::obj_nib_t      code_hi,
    output obj_pkg::obj_word_t     obj_code,
    output obj_pkg::obj_word_t     obj_attr,
    output obj_pkg::obj_word_t     obj_y,
    output obj_pkg::obj_line_t     line,
    output obj_pkg::obj_nib_t      col,
    output logic                   dr_start,
    output obj_pkg::obj_word_t     dr_code,
    output obj_pkg::obj_word_t     dr_attr,
    output obj_pkg::obj_hpos_t     dr_hpos,
    output logic                   line_done,
    output logic                   busy
);
    import obj_pkg::*;

    localparam int ADDR_W = `OBJ_ADDR_W;
    localparam logic [ADDR_W-1:0] TOP_ADDR = ADDR_W'(4 * `OBJ_ENTRIES - 1); // attr of last entry

    scan_state_t state;

    obj_word_t code_q;       // raw code word, before mapping
    obj_word_t obj_x;
    obj_word_t prev_attr;    // last drawn entry, mapped code
    obj_word_t prev_code;
    obj_word_t prev_y;
    obj_word_t prev_x;
    obj_nib_t  mask_q;       // bank settings held from start
    obj_nib_t  offset_q;
    obj_nib_t  npos;         // column position, reversed by hflip
    logic      first;        // no visible entry yet this line

    obj_nib_t  tile_n;
    logic      hflip;
    logic      skip;
    logic      repeated;
    logic      draw_ok;

    assign tile_n = obj_attr[11:8];
    assign hflip  = obj_attr[5];

    // bank rule, checked against the start-time mask as well
    assign skip = unmapped | (|(code_q[15:12] & ~mask_q));

    assign repeated = (obj_attr == prev_attr) && (obj_code == prev_code) &&
                      (obj_y == prev_y) && (obj_x == prev_x);
    assign draw_ok  = inzone && (first || !repeated);

    // control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= SCAN_IDLE;
            rd_addr   <= '0;
            busy      <= 1'b0;
            line_done <= 1'b0;
            dr_start  <= 1'b0;
            first     <= 1'b0;
            col       <= 4'd0;
            npos      <= 4'd0;
        end else begin
            line_done <= 1'b0;
            case (state)
                SCAN_IDLE: begin
                    if (start) begin
                        rd_addr <= TOP_ADDR;
                        busy    <= 1'b1;
                        first   <= 1'b1;
                        state   <= SCAN_ATTR;
                    end
                end
                SCAN_ATTR: begin
                    rd_addr <= rd_addr - 1'b1; // to code
                    state   <= SCAN_CODE;
                end
                SCAN_CODE: begin
                    rd_addr <= rd_addr - 1'b1; // to y
                    state   <= SCAN_Y;
                end
                SCAN_Y: begin
                    rd_addr <= rd_addr - 1'b1; // to x
                    state   <= SCAN_X;
                end
                SCAN_X: state <= SCAN_MAP; // address parks on x
                SCAN_MAP: state <= skip ? SCAN_NEXT : SCAN_VIS;
                SCAN_VIS: begin
                    if (draw_ok) begin
                        first <= 1'b0;
                        col   <= 4'd0;
                        npos  <= hflip ? tile_n : 4'd0; // hflip starts at the far column
                        state <= SCAN_REQ;
                    end else begin
                        state <= SCAN_NEXT;
                    end
                end
                SCAN_REQ: begin
                    if (dr_idle) begin
                        dr_start <= 1'b1;
                        state    <= SCAN_HOLD;
                    end
                end
                SCAN_HOLD: begin
                    dr_start <= 1'b0;
                    if (col == tile_n) begin
                        state <= SCAN_NEXT;
                    end else begin
                        col   <= col + 1'b1;
                        npos  <= hflip ? npos - 1'b1 : npos + 1'b1;
                        state <= SCAN_REQ;
                    end
                end
                SCAN_NEXT: begin
                    if (rd_addr == '0) begin
                        // entry 0 done, close only once the last tile is out
                        if (dr_idle) begin
                            busy      <= 1'b0;
                            line_done <= 1'b1;
                            state     <= SCAN_IDLE;
                        end
                    end else begin
                        rd_addr <= rd_addr - 1'b1; // attr of next entry down
                        state   <= SCAN_ATTR;
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    // entry and request payload
    always_ff @(posedge clk) begin
        case (state)
            SCAN_IDLE: begin
                if (start) begin
                    line     <= vrender ^ {1'b0, {8{flip}}}; // flipped screen counts up
                    mask_q   <= bank_mask;
                    offset_q <= bank_offset;
                end
            end
            SCAN_CODE: obj_attr <= rd_data;
            SCAN_Y: begin
                code_q  <= rd_data;
                code_hi <= rd_data[15:12]; // to mapper, result in SCAN_MAP
            end
            SCAN_X: obj_y <= rd_data;
            SCAN_MAP: begin
                obj_x    <= rd_data;
                obj_code <= {map_hi | offset_q, code_q[11:0]};
            end
            SCAN_VIS: begin
                if (draw_ok) begin
                    prev_attr <= obj_attr;
                    prev_code <= obj_code;
                    prev_y    <= obj_y;
                    prev_x    <= obj_x;
                end
            end
            SCAN_REQ: begin
                if (dr_idle) begin
                    dr_code <= code_mn;
                    dr_attr <= {4'd0, vsub, obj_attr[7:0]};
                    dr_hpos <= obj_x[8:0] + {1'b0, npos, 4'd0} - 9'd1; // 16 px per column
                end
            end
            default: ;
        endcase
    end

    // drawer still idle while the strobe is out
    a_req_idle : assert property (
        @(posedge clk) disable iff (rst) dr_start |-> dr_idle
    ) else $error("line scan: dr_start while drawer busy");

    a_addr_busy : assert property (
        @(posedge clk) disable iff (rst) !$stable(rd_addr) |-> busy
    ) else $error("line scan: rd_addr moved while idle");

    // a start during the scan leaves the latched line untouched
    a_start_busy : assert property (
        @(posedge clk) disable iff (rst) (start && busy) |=> $stable(line)
    ) else $error("line scan: start while busy was taken");

endmodule

/* src/obj_tile_draw.sv */
// tile drawer stand-in: busy counter per request, tile record strobe at the end

`timescale 1ns/1ns
`include "obj_config.svh"

module obj_tile_draw (
    input  logic               clk,
    input  logic               rst,
    input  logic               dr_start,
    input  obj_pkg::obj_word_t dr_code,
    input  obj_pkg::obj_word_t dr_attr,
    input  obj_pkg::obj_hpos_t dr_hpos,
    output logic               dr_idle,
    output logic               tile_valid,
    output obj_pkg::obj_word_t tile_code,
    output obj_pkg::obj_word_t tile_attr,
    output obj_pkg::obj_hpos_t tile_hpos
);

    localparam int CNT_W = $clog2(`OBJ_DRAW_CYCLES + 1);

    logic [CNT_W-1:0] cnt; // cycles left, stands in for the ROM fetch

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dr_idle    <= 1'b1;
            tile_valid <= 1'b0;
            cnt        <= '0;
        end else begin
            tile_valid <= 1'b0;
            if (dr_start && dr_idle) begin
                dr_idle <= 1'b0;
                cnt     <= CNT_W'(`OBJ_DRAW_CYCLES - 1);
            end else if (!dr_idle) begin
                if (cnt == CNT_W'(1)) begin
                    tile_valid <= 1'b1; // record and idle together
                    dr_idle    <= 1'b1;
                end
                cnt <= cnt - 1'b1;
            end
        end
    end

    // request held for the record
    always_ff @(posedge clk) begin
        if (dr_start && dr_idle) begin
            tile_code <= dr_code;
            tile_attr <= dr_attr;
            tile_hpos <= dr_hpos;
        end
    end

    a_no_overlap : assert property (
        @(posedge clk) disable iff (rst) !dr_idle |-> !dr_start
    ) else $error("tile draw: request while drawing");

endmodule

/* src/obj_line_top.sv */
// object line top: frame table, scanner, bank mapper, tile match and drawer

`timescale 1ns/1ns
`include "obj_config.svh"

module obj_line_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   table_we,
    input  logic [`OBJ_ADDR_W-1:0] table_addr,
    input  obj_pkg::obj_word_t     table_din,
    input  logic                   start,
    input  logic                   flip,
    input  obj_pkg::obj_line_t     vrender,
    input  obj_pkg::obj_nib_t      bank_mask,
    input  obj_pkg::obj_nib_t      bank_offset,
    output logic                   tile_valid,
    output obj_pkg::obj_word_t     tile_code,
    output obj_pkg::obj_word_t     tile_attr,
    output obj_pkg::obj_hpos_t     tile_hpos,
    output logic                   line_done,
    output logic                   busy
);
    import obj_pkg::*;

    logic [`OBJ_ADDR_W-1:0] rd_addr;
    obj_word_t rd_data;
    obj_nib_t  code_hi;      // scanner to mapper
    obj_nib_t  map_hi;
    logic      unmapped;
    obj_word_t obj_code;     // scanner to match
    obj_word_t obj_attr;
    obj_word_t obj_y;
    obj_line_t line;
    obj_nib_t  col;
    logic      inzone;       // match back to scanner
    obj_nib_t  vsub;
    obj_word_t code_mn;
    logic      dr_start;     // scanner to drawer
    logic      dr_idle;
    obj_word_t dr_code;
    obj_word_t dr_attr;
    obj_hpos_t dr_hpos;

    obj_frame_table u_table (
        .clk        (clk),
        .table_we   (table_we),
        .table_addr (table_addr),
        .table_din  (table_din),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    obj_bank_mapper u_mapper (
        .clk         (clk),
        .rst         (rst),
        .code_hi     (code_hi),
        .bank_mask   (bank_mask),
        .bank_offset (bank_offset),
        .map_hi      (map_hi),
        .unmapped    (unmapped)
    );

    obj_tile_match u_match (
        .obj_code (obj_code),
        .obj_attr (obj_attr),
        .obj_y    (obj_y),
        .line     (line),
        .col      (col),
        .inzone   (inzone),
        .vsub     (vsub),
        .code_mn  (code_mn)
    );

    obj_line_scan u_scan (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .flip        (flip),
        .vrender     (vrender),
        .bank_mask   (bank_mask),
        .bank_offset (bank_offset),
        .rd_data     (rd_data),
        .map_hi      (map_hi),
        .unmapped    (unmapped),
        .inzone      (inzone),
        .vsub        (vsub),
        .code_mn     (code_mn),
        .dr_idle     (dr_idle),
        .rd_addr     (rd_addr),
        .code_hi     (code_hi),
        .obj_code    (obj_code),
        .obj_attr    (obj_attr),
        .obj_y       (obj_y),
        .line        (line),
        .col         (col),
        .dr_start    (dr_start),
        .dr_code     (dr_code),
        .dr_attr     (dr_attr),
        .dr_hpos     (dr_hpos),
        .line_done   (line_done),
        .busy        (busy)
    );

    obj_tile_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .dr_start   (dr_start),
        .dr_code    (dr_code),
        .dr_attr    (dr_attr),
        .dr_hpos    (dr_hpos),
        .dr_idle    (dr_idle),
        .tile_valid (tile_valid),
        .tile_code  (tile_code),
        .tile_attr  (tile_attr),
        .tile_hpos  (tile_hpos)
    );

endmodule

/* verification/obj_line_tb.sv */
// object line scanner testbench: table loader, reference model, record comparer, tests

`timescale 1ns/1ns
`include "obj_config.svh"

module obj_line_tb;
    import obj_pkg::*;

    localparam int ADDR_W  = `OBJ_ADDR_W;
    localparam int N_LINES = 28; // scans over all tests
    localparam int LIMIT   = N_LINES * (256 * 8 + 256 * 16 * (`OBJ_DRAW_CYCLES + 4));

    logic              clk;
    logic              rst;
    logic              table_we;
    logic [ADDR_W-1:0] table_addr;
    obj_word_t         table_din;
    logic              start;
    logic              flip;
    obj_line_t         vrender;
    obj_nib_t          bank_mask;
    obj_nib_t          bank_offset;
    logic              tile_valid;
    obj_word_t         tile_code;
    obj_word_t         tile_attr;
    obj_hpos_t         tile_hpos;
    logic              line_done;
    logic              busy;

    obj_word_t mirror [0:`OBJ_TABLE_WORDS-1]; // copy of what the host wrote
    obj_word_t exp_code [$];                   // expected records, in draw order
    obj_word_t exp_attr [$];
    obj_hpos_t exp_hpos [$];
    obj_word_t e_code;
    obj_word_t e_attr;
    obj_hpos_t e_hpos;

    logic [31:0] seed = 32'hdadb_a581;
    int errors    = 0;
    int checks    = 0;
    int rec_count = 0; // records seen this line
    int cycles    = 0;

    obj_line_top dut (
        .clk         (clk),
        .rst         (rst),
        .table_we    (table_we),
        .table_addr  (table_addr),
        .table_din   (table_din),
        .start       (start),
        .flip        (flip),
        .vrender     (vrender),
        .bank_mask   (bank_mask),
        .bank_offset (bank_offset),
        .tile_valid  (tile_valid),
        .tile_code   (tile_code),
        .tile_attr   (tile_attr),
        .tile_hpos   (tile_hpos),
        .line_done   (line_done),
        .busy        (busy)
    );

    always #20 clk = ~clk; // 40 ns period

    // run limit from the worst case line length
    always @(posedge clk) begin
        cycles++;
        if (cycles == LIMIT) begin
            $display("timeout: no end of test after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // lcg, upper bits used by callers
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic void set_entry(input int k, input obj_word_t a, input obj_word_t c,
                                      input obj_word_t y, input obj_word_t x);
        mirror[4*k+3] = a;
        mirror[4*k+2] = c;
        mirror[4*k+1] = y;
        mirror[4*k+0] = x;
    endfunction

    // every entry 1x1, code 0, 256 lines away from the test line
    function automatic void clear_table(input obj_line_t y_far);
        int k;
        for (k = 0; k < `OBJ_ENTRIES; k++) begin
            set_entry(k, 16'h0000, 16'h0000, {7'd0, y_far}, 16'h0000);
        end
    endfunction

    // expected records of one line: bank, visibility, repeat, expansion
    function automatic void build_expected(input logic flp, input obj_line_t vr,
                                           input obj_nib_t msk, input obj_nib_t ofs);
        obj_line_t ln;
        obj_line_t dy;
        obj_word_t a;
        obj_word_t c;
        obj_word_t y;
        obj_word_t x;
        obj_word_t mc;
        obj_word_t pa;
        obj_word_t pc;
        obj_word_t py;
        obj_word_t px;
        logic      have_prev;
        int        k;
        int        n;
        int        m;
        int        nmax;
        int        dyi;
        int        row;
        int        sub;
        int        npos;
        ln        = vr ^ (flp ? 9'h0ff : 9'h000);
        have_prev = 1'b0;
        pa = '0;
        pc = '0;
        py = '0;
        px = '0;
        for (k = `OBJ_ENTRIES - 1; k >= 0; k--) begin
            a = mirror[4*k+3];
            c = mirror[4*k+2];
            y = mirror[4*k+1];
            x = mirror[4*k+0];
            if ((c[15:12] & ~msk) != 4'd0) continue; // outside the bank
            mc   = {(c[15:12] & msk) | ofs, c[11:0]};
            dy   = ln - y[8:0];
            dyi  = int'(dy);
            m    = int'(a[15:12]);
            nmax = int'(a[11:8]);
            if (dyi >= 16 * (m + 1)) continue; // off the line
            if (have_prev && a == pa && mc == pc && y == py && x == px) continue;
            have_prev = 1'b1;
            pa = a;
            pc = mc;
            py = y;
            px = x;
            row = dyi / 16;
            sub = dyi % 16;
            if (a[6]) begin
                row = m - row;
                sub = 15 - sub;
            end
            for (n = 0; n <= nmax; n++) begin
                npos = a[5] ? nmax - n : n; // hflip walks from the far side
                exp_code.push_back(mc + 16'(n + 16 * row));
                exp_attr.push_back({4'd0, 4'(sub), a[7:0]});
                exp_hpos.push_back(x[8:0] + 9'(16 * npos) - 9'd1);
            end
        end
    endfunction

    // single-bit output against its expected level
    task automatic check_bit(input string name, input logic exp, input logic got);
        checks++;
        assert (got == exp) else begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, got);
            errors++;
        end
    endtask

    // compare each record as it comes out
    always @(negedge clk) begin
        if (!rst && tile_valid) begin
            rec_count++;
            checks++;
            assert (exp_code.size() != 0) else begin
                $display("t=%0t: tile record drawn with no expected record left", $time);
                errors++;
            end
            if (exp_code.size() != 0) begin
                e_code = exp_code.pop_front();
                e_attr = exp_attr.pop_front();
                e_hpos = exp_hpos.pop_front();
                checks += 3;
                assert (tile_code == e_code) else begin
                    $display("FAIL t=%0t tile_code expected %h got %h", $time, e_code, tile_code);
                    errors++;
                end
                assert (tile_attr == e_attr) else begin
                    $display("FAIL t=%0t tile_attr expected %h got %h", $time, e_attr, tile_attr);
                    errors++;
                end
                assert (tile_hpos == e_hpos) else begin
                    $display("FAIL t=%0t tile_hpos expected %h got %h", $time, e_hpos, tile_hpos);
                    errors++;
                end
            end
        end
    end

    // whole table through the host port, one word per cycle
    task automatic load_table();
        int i;
        for (i = 0; i < `OBJ_TABLE_WORDS; i++) begin
            @(posedge clk);
            #2;
            table_we   = 1'b1;
            table_addr = ADDR_W'(i);
            table_din  = mirror[i];
        end
        @(posedge clk);
        #2;
        table_we = 1'b0;
    endtask

    // one scan, n_exp below zero skips the count check
    task automatic run_line(input logic flp, input obj_line_t vr, input obj_nib_t msk,
                            input obj_nib_t ofs, input int n_exp);
        build_expected(flp, vr, msk, ofs);
        rec_count = 0;
        @(posedge clk);
        #2;
        flip        = flp;
        vrender     = vr;
        bank_mask   = msk;
        bank_offset = ofs;
        start       = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        check_bit("busy", 1'b1, busy); // scan under way
        // second start mid-scan on another line, scanner keeps the first one
        @(posedge clk);
        #2;
        flip    = ~flp;
        vrender = ~vr;
        start   = 1'b1;
        @(posedge clk);
        #2;
        start   = 1'b0;
        flip    = flp;
        vrender = vr;
        do @(negedge clk); while (!line_done);
        check_bit("busy", 1'b0, busy); // drops with line_done
        checks++;
        assert (exp_code.size() == 0) else begin
            $display("t=%0t: line ended with %0d expected records not drawn",
                     $time, exp_code.size());
            errors++;
            exp_code.delete();
            exp_attr.delete();
            exp_hpos.delete();
        end
        if (n_exp >= 0) begin
            checks++;
            assert (rec_count == n_exp) else begin
                $display("FAIL t=%0t record count expected %0d got %0d", $time, n_exp, rec_count);
                errors++;
            end
        end
    endtask

    task automatic test_single();
        clear_table(9'd356);
        set_entry(37, 16'h001a, 16'h0123, 16'd95, 16'd40); // dy 5
        load_table();
        run_line(1'b0, 9'd100, 4'hf, 4'h0, 1);
    endtask

    task automatic test_wide();
        clear_table(9'd456);
        set_entry(10, 16'h0300, 16'h0ab0, 16'd200, 16'd300); // four columns
        load_table();
        run_line(1'b0, 9'd200, 4'hf, 4'h0, 4);
        set_entry(10, 16'h0320, 16'h0ab0, 16'd200, 16'd300); // same, hflip
        load_table();
        run_line(1'b0, 9'd200, 4'hf, 4'h0, 4);
    endtask

    task automatic test_vflip();
        clear_table(9'd306); // far from lines 50 and 35
        set_entry(120, 16'h2140, 16'h0400, 16'd30, 16'd64); // 3 rows, 2 columns, vflip
        load_table();
        run_line(1'b0, 9'd50, 4'hf, 4'h0, 2);  // line 50, row 1
        run_line(1'b1, 9'd220, 4'hf, 4'h0, 2); // flipped to line 35, row 0
    endtask

    task automatic test_bank();
        clear_table(9'd266);
        set_entry(90, 16'h0000, 16'h1234, 16'd10, 16'd20);
        set_entry(80, 16'h0000, 16'h8abc, 16'd10, 16'd60); // bit 3 not in mask
        set_entry(70, 16'h0000, 16'h3fff, 16'd10, 16'd100);
        load_table();
        run_line(1'b0, 9'd10, 4'b0011, 4'b0100, 2);
    endtask

    task automatic test_repeat();
        clear_table(9'd44);
        set_entry(200, 16'h0105, 16'h0200, 16'd295, 16'd80);
        set_entry(199, 16'h0105, 16'h0200, 16'd295, 16'd80); // dropped
        set_entry(150, 16'h0000, 16'h0300, 16'd300, 16'd10);
        set_entry(149, 16'h0105, 16'h0200, 16'd295, 16'd80); // differs from 150
        load_table();
        run_line(1'b0, 9'd300, 4'hf, 4'h0, 5);
        run_line(1'b0, 9'd300, 4'hf, 4'h0, 5); // line starts with last drawn entry again
    endtask

    task automatic test_random();
        logic [31:0] r;
        int t;
        int i;
        int k;
        for (t = 0; t < 20; t++) begin
            for (i = 0; i < `OBJ_TABLE_WORDS; i++) begin
                r = next_random();
                mirror[i] = r[31:16];
            end
            // some entries copied from the one above, so repeats happen
            for (k = `OBJ_ENTRIES - 2; k >= 0; k--) begin
                r = next_random();
                if (r[31:29] == 3'd0) begin
                    for (i = 0; i < 4; i++) begin
                        mirror[4*k+i] = mirror[4*k+4+i];
                    end
                end
            end
            load_table();
            r = next_random();
            run_line(r[20], r[31:23], r[19:16], r[15:12], -1);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        table_we    = 1'b0;
        table_addr  = '0;
        table_din   = '0;
        start       = 1'b0;
        flip        = 1'b0;
        vrender     = '0;
        bank_mask   = 4'hf;
        bank_offset = 4'h0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        // quiet outputs out of reset
        check_bit("busy", 1'b0, busy);
        check_bit("line_done", 1'b0, line_done);
        check_bit("tile_valid", 1'b0, tile_valid);

        test_single();
        test_wide();
        test_vflip();
        test_bank();
        test_repeat();
        test_random();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+src
src/obj_pkg.sv
src/obj_frame_table.sv
src/obj_bank_mapper.sv
src/obj_tile_match.sv
src/obj_line_scan.sv
src/obj_tile_draw.sv
src/obj_line_top.sv
verification/obj_line_tb.sv

/* Makefile */
TOP = obj_line_tb

all: run

build:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module obj_line_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
